// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_TEXT ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
src/fetch_pkg.sv
src/icache_array.sv
src/refill_engine.sv
src/fetch_control.sv
src/fetch_top.sv
verification/fetch_chk.sv
verification/fetch_tb.sv

// File: src/fetch_control.sv
`timescale 1ns/1ps

module fetch_control import fetch_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        lookup_done,
	input  logic        lookup_hit,
	input  logic [31:0] lookup_word,
	input  logic        refill_done,
	input  logic [31:0] refill_word,
	input  logic        redirect,
	input  logic [31:0] redirect_pc,
	input  logic        inst_ready,
	output logic        lookup_valid,
	output logic [31:0] lookup_pc,
	output logic        miss_start,
	output logic [31:0] miss_pc,
	output logic [31:0] inst,
	output logic [31:0] inst_pc,
	output logic        inst_valid
);

	fetch_state_t state;

	logic [31:0] pc;
	logic        discard;   // Redirect seen during refill
	logic [31:0] target;    // Its target
	logic        load_hit;
	logic        load_refill;

	assign load_hit    = (state == fetch_lookup) && lookup_done && lookup_hit && !redirect;
	assign load_refill = (state == fetch_refill) && refill_done && !redirect && !discard;
	assign miss_start  = (state == fetch_lookup) && lookup_done && !lookup_hit && !redirect;

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= fetch_issue;
			pc      <= reset_pc;
			discard <= 1'b0;
		end else begin
			case (state)
				fetch_issue: begin
					if (redirect)
						pc <= redirect_pc; // Stale lookup result is ignored
					else
						state <= fetch_lookup;
				end
				fetch_lookup: begin
					if (redirect) begin
						pc    <= redirect_pc;
						state <= fetch_issue;
					end else if (lookup_done) begin
						state <= lookup_hit ? fetch_hold : fetch_refill;
					end
				end
				fetch_refill: begin
					if (refill_done) begin
						if (redirect)
							pc <= redirect_pc;
						else if (discard)
							pc <= target;
						state   <= (redirect || discard) ? fetch_issue : fetch_hold;
						discard <= 1'b0;
					end else if (redirect) begin
						discard <= 1'b1; // Let the line finish filling
					end
				end
				fetch_hold: begin
					if (redirect) begin
						pc    <= redirect_pc;
						state <= fetch_issue;
					end else if (inst_ready) begin
						pc    <= pc + 32'd4;
						state <= fetch_issue;
					end
				end
				default: state <= fetch_issue;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == fetch_refill && redirect)
			target <= redirect_pc; // Latest redirect wins
		if (load_hit) begin
			inst    <= lookup_word;
			inst_pc <= pc;
		end else if (load_refill) begin
			inst    <= refill_word;
			inst_pc <= pc;
		end
	end

	assign lookup_valid = (state == fetch_issue);
	assign lookup_pc    = pc;
	assign miss_pc      = pc;
	assign inst_valid   = (state == fetch_hold);

endmodule

// File: src/fetch_pkg.sv
package fetch_pkg;

	// Fetch address after reset
	localparam logic [31:0] reset_pc = 32'h3000_0000;

	// Cache geometry of 16 lines by 8 words
	localparam int line_words       = 8;
	localparam int line_offset_bits = 5;
	localparam int index_bits       = 4;
	localparam int tag_bits         = 32 - index_bits - line_offset_bits;

	// Derived sizes
	localparam int word_bits = line_offset_bits - 2; // Word select within a line
	localparam int num_lines = 1 << index_bits;

	// Fetch FSM
	typedef enum logic [1:0] {
		fetch_issue,  // Present PC to cache
		fetch_lookup, // Waiting on lookup result
		fetch_refill, // Waiting on refill_done
		fetch_hold    // Output valid
	} fetch_state_t;

	// Refill FSM
	typedef enum logic [1:0] {
		refill_idle,
		refill_addr, // Address phase
		refill_data  // Beat phase
	} refill_state_t;

endpackage

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
	input  logic        clock,
	input  logic        reset,
	output logic [31:0] mem_araddr,
	output logic        mem_arvalid,
	input  logic        mem_arready,
	input  logic [31:0] mem_rdata,
	input  logic        mem_rvalid,
	input  logic        mem_rlast,
	input  logic        redirect,
	input  logic [31:0] redirect_pc,
	output logic [31:0] inst,
	output logic [31:0] inst_pc,
	output logic        inst_valid,
	input  logic        inst_ready
);

	logic        lookup_valid;
	logic [31:0] lookup_pc;
	logic        lookup_done;
	logic        lookup_hit;
	logic [31:0] lookup_word;
	logic        miss_start;
	logic [31:0] miss_pc;
	logic        fill_we;
	logic [31:0] fill_addr;
	logic [31:0] fill_data;
	logic        fill_last;
	logic        refill_done;
	logic [31:0] refill_word;

	icache_array cache0 (.*);

	refill_engine refill0 (.*);

	fetch_control control0 (.*);

endmodule

// File: src/icache_array.sv
`timescale 1ns/1ps

module icache_array import fetch_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        lookup_valid,
	input  logic [31:0] lookup_pc,
	input  logic        fill_we,
	input  logic [31:0] fill_addr,
	input  logic [31:0] fill_data,
	input  logic        fill_last,
	output logic        lookup_done,
	output logic        lookup_hit,
	output logic [31:0] lookup_word
);

	logic [31:0]         data_mem [num_lines*line_words];
	logic [tag_bits-1:0] tag_mem  [num_lines];
	logic [num_lines-1:0] line_valid;

	logic [index_bits-1:0] req_index;
	logic [word_bits-1:0]  req_offset;
	logic [tag_bits-1:0]   req_tag;
	logic [index_bits-1:0] fill_index;
	logic [word_bits-1:0]  fill_offset;
	logic [tag_bits-1:0]   fill_tag;

	logic [tag_bits-1:0] tag_q;
	logic [tag_bits-1:0] req_tag_q;
	logic                valid_q;

	assign req_index   = lookup_pc[line_offset_bits +: index_bits];
	assign req_offset  = lookup_pc[2 +: word_bits];
	assign req_tag     = lookup_pc[31 -: tag_bits];
	assign fill_index  = fill_addr[line_offset_bits +: index_bits];
	assign fill_offset = fill_addr[2 +: word_bits];
	assign fill_tag    = fill_addr[31 -: tag_bits];

	// Registered read of data, tag and valid
	always_ff @(posedge clock) begin
		if (lookup_valid) begin
			lookup_word <= data_mem[{req_index, req_offset}];
			tag_q       <= tag_mem[req_index];
			valid_q     <= line_valid[req_index];
			req_tag_q   <= req_tag;
		end
		if (fill_we) begin
			data_mem[{fill_index, fill_offset}] <= fill_data;
			if (fill_last)
				tag_mem[fill_index] <= fill_tag; // Tag goes in with the last beat
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			lookup_done <= 1'b0;
			line_valid  <= '0;
		end else begin
			lookup_done <= lookup_valid;
			if (fill_we && fill_last)
				line_valid[fill_index] <= 1'b1;
		end
	end

	// Compare in the result cycle
	assign lookup_hit = valid_q && (tag_q == req_tag_q);

endmodule

// File: src/refill_engine.sv
`timescale 1ns/1ps

module refill_engine import fetch_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        miss_start,
	input  logic [31:0] miss_pc,
	input  logic        mem_arready,
	input  logic [31:0] mem_rdata,
	input  logic        mem_rvalid,
	input  logic        mem_rlast,
	output logic [31:0] mem_araddr,
	output logic        mem_arvalid,
	output logic        fill_we,
	output logic [31:0] fill_addr,
	output logic [31:0] fill_data,
	output logic        fill_last,
	output logic        refill_done,
	output logic [31:0] refill_word
);

	refill_state_t state;

	logic [31:0]          line_base;
	logic [word_bits-1:0] want_offset; // Word the fetch is waiting for
	logic [word_bits-1:0] beat_cnt;

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= refill_idle;
			beat_cnt    <= '0;
			refill_done <= 1'b0;
		end else begin
			refill_done <= 1'b0;
			case (state)
				refill_idle: begin
					if (miss_start)
						state <= refill_addr;
				end
				refill_addr: begin
					if (mem_arready) begin
						state    <= refill_data;
						beat_cnt <= '0;
					end
				end
				refill_data: begin
					if (mem_rvalid) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (mem_rlast) begin
							state       <= refill_idle;
							refill_done <= 1'b1;
						end
					end
				end
				default: state <= refill_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == refill_idle && miss_start) begin
			line_base   <= {miss_pc[31:line_offset_bits], {line_offset_bits{1'b0}}};
			want_offset <= miss_pc[2 +: word_bits];
		end
		if (fill_we && beat_cnt == want_offset)
			refill_word <= mem_rdata;
	end

	// Burst address held until accepted
	assign mem_arvalid = (state == refill_addr);
	assign mem_araddr  = line_base;

	// Every beat goes straight into the array
	assign fill_we   = (state == refill_data) && mem_rvalid;
	assign fill_addr = {line_base[31:line_offset_bits], beat_cnt, 2'b00};
	assign fill_data = mem_rdata;
	assign fill_last = fill_we && mem_rlast;

endmodule

// File: verification/fetch_chk.sv
`timescale 1ns/1ps

module fetch_chk (
	input logic        clock,
	input logic        reset,
	input logic [31:0] inst,
	input logic [31:0] inst_pc,
	input logic        inst_valid,
	input logic        inst_ready,
	input logic        redirect,
	input logic [31:0] mem_araddr,
	input logic        mem_arvalid,
	input logic        mem_arready,
	input logic [31:0] lookup_pc
);

	int   fail_count = 0; // Read by the testbench at the end
	logic burst_seen;

	function automatic void record_failure(input string what);
		fail_count = fail_count + 1;
		$error("%s", what);
	endfunction

	always_ff @(posedge clock) begin
		if (reset)
			burst_seen <= 1'b0;
		else if (mem_arvalid)
			burst_seen <= 1'b1;
	end

	// Memory holds ~A at A, so this covers hit and refill data
	inst_matches_pc: assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> inst == ~inst_pc)
		else record_failure("inst is not the inverse of inst_pc");

	hold_stable: assert property (@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready && !redirect |=> inst_valid && $stable(inst) && $stable(inst_pc))
		else record_failure("instruction changed or dropped under back-pressure");

	araddr_aligned: assert property (@(posedge clock) disable iff (reset)
		mem_arvalid |-> mem_araddr[4:0] == 5'd0)
		else record_failure("burst address is not line aligned");

	araddr_is_pc_line: assert property (@(posedge clock) disable iff (reset)
		mem_arvalid |-> mem_araddr[31:5] == lookup_pc[31:5])
		else record_failure("burst address is not the line of the fetch PC");

	ar_held: assert property (@(posedge clock) disable iff (reset)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
		else record_failure("burst request dropped or changed before arready");

	idle_in_reset: assert property (@(posedge clock) reset |=> !inst_valid && !mem_arvalid)
		else record_failure("inst_valid or mem_arvalid high during or right after reset");

	first_burst: assert property (@(posedge clock) disable iff (reset)
		mem_arvalid && !burst_seen |-> mem_araddr == 32'h3000_0000)
		else record_failure("first burst is not the reset PC line");

endmodule

// File: verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

	localparam logic [31:0] start_pc   = 32'h3000_0000;
	localparam logic [31:0] lfsr_seed  = 32'hbf847244;
	localparam logic [31:0] lfsr_taps  = 32'h8020_0003;
	localparam int          inst_total = 400;
	localparam int          run_limit  = 40000; // Cycles

	logic        clock;
	logic        reset;
	logic [31:0] mem_araddr;
	logic        mem_arvalid;
	logic        mem_arready;
	logic [31:0] mem_rdata;
	logic        mem_rvalid;
	logic        mem_rlast;
	logic        redirect;
	logic [31:0] redirect_pc;
	logic [31:0] inst;
	logic [31:0] inst_pc;
	logic        inst_valid;
	logic        inst_ready;

	logic [31:0] lfsr;
	int          reset_count;
	int          accepted;
	int          pc_errors;
	int          refill_errors;
	logic [31:0] expect_pc;

	int          ar_wait;     // Cycles left before arready
	logic        ar_pending;
	logic        in_burst;
	logic [31:0] burst_base;
	logic [2:0]  beat;

	logic        model_valid [16]; // Lines the cache should hold
	logic [22:0] model_tag   [16];

	fetch_top dut0 (.*);

	bind fetch_top fetch_chk chk0 (.*);

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr  = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	task automatic note_refill(input logic [31:0] addr);
		logic [3:0]  index;
		logic [22:0] tag;
		index = addr[8:5];
		tag   = addr[31:9];
		assert (!(model_valid[index] && model_tag[index] == tag)) else begin
			refill_errors++;
			$display("** Error at %0d ns: unexpected refill of resident line %h", $time, addr);
		end
		model_valid[index] = 1'b1;
		model_tag[index]   = tag;
	endtask

	// Burst slave that returns ~A as the word at A
	task automatic memory_step();
		mem_arready = 1'b0;
		mem_rvalid  = 1'b0;
		mem_rlast   = 1'b0;
		if (in_burst) begin
			if (random_bits(2) != 0) begin // Gap one cycle in four
				mem_rvalid = 1'b1;
				mem_rdata  = ~(burst_base + {27'd0, beat, 2'b00});
				mem_rlast  = (beat == 3'd7);
				if (beat == 3'd7)
					in_burst = 1'b0;
				beat = beat + 3'd1;
			end
		end else if (mem_arvalid) begin
			if (!ar_pending) begin
				ar_pending = 1'b1;
				ar_wait    = int'(random_bits(2));
			end
			if (ar_wait == 0) begin
				mem_arready = 1'b1;
				ar_pending  = 1'b0;
				in_burst    = 1'b1;
				beat        = 3'd0;
				burst_base  = mem_araddr;
				note_refill(mem_araddr);
			end else begin
				ar_wait--;
			end
		end
	endtask

	task automatic consumer_step();
		inst_ready = (random_bits(2) != 0);
		redirect   = (random_bits(6) == 0);
		if (redirect) begin
			if (random_bits(1) == 1)
				redirect_pc = start_pc;
			else
				redirect_pc = start_pc + (random_bits(9) << 2); // 2 KB window
			expect_pc = redirect_pc;
		end
		// Shown instruction is dropped in a redirect cycle
		if (inst_valid && inst_ready && !redirect) begin
			assert (inst_pc == expect_pc) else begin
				pc_errors++;
				$display("** Error at %0d ns: inst_pc %h, expected %h", $time, inst_pc, expect_pc);
			end
			expect_pc = expect_pc + 32'd4;
			accepted++;
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		#1;
		if (reset) begin
			reset_count++;
			if (reset_count == 3)
				reset = 1'b0;
		end else begin
			memory_step();
			consumer_step();
		end
	end

	initial begin
		int cycles;
		int chk_errors;
		int timeouts;
		reset       = 1'b1;
		mem_arready = 1'b0;
		mem_rdata   = '0;
		mem_rvalid  = 1'b0;
		mem_rlast   = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;
		inst_ready  = 1'b0;
		lfsr        = lfsr_seed;
		reset_count = 0;
		accepted    = 0;
		pc_errors   = 0;
		refill_errors = 0;
		expect_pc   = start_pc;
		ar_wait     = 0;
		ar_pending  = 1'b0;
		in_burst    = 1'b0;
		beat        = 3'd0;
		burst_base  = '0;
		for (int i = 0; i < 16; i++)
			model_valid[i] = 1'b0;

		cycles = 0;
		while (accepted < inst_total && cycles < run_limit) begin
			@(posedge clock);
			cycles++;
		end
		timeouts = 0;
		if (accepted < inst_total) begin
			timeouts = 1;
			$display("Timed out after %0d cycles with only %0d of %0d instructions accepted",
				cycles, accepted, inst_total);
		end
		chk_errors = dut0.chk0.fail_count;
		$display("Accepted %0d, PC errors %0d, refill errors %0d, assertion errors %0d, timeouts %0d",
			accepted, pc_errors, refill_errors, chk_errors, timeouts);
		if (pc_errors == 0 && refill_errors == 0 && chk_errors == 0 && timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
